// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;   // data and address width
    localparam int REG_ADDR_W = 5;    // x0..x31

    // alu operation, 3 bits
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } alu_op_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,   // decode/execute register
        FWD_WB   = 2'b01,   // writeback result
        FWD_MEM  = 2'b10    // alu result sitting in memory stage
    } fwd_sel_e;

    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000;   // add, sub, addi
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;   // lw and sw
    localparam logic [2:0] F3_BEQ  = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;   // addi x0,x0,0

endpackage

`default_nettype wire

// File: decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  logic [31:0]                    instr_i,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs2_o,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rd_o,
    output logic [rv_pkg::XLEN-1:0]        imm_o,
    output rv_pkg::alu_op_e                alu_op_o,
    output logic                           alu_src_imm_o,   // b operand is the immediate
    output logic                           reg_we_o,
    output logic                           mem_re_o,
    output logic                           mem_we_o,
    output logic                           branch_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;   // anything outside the supported subset

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb
    begin
        rs1_o         = instr_i[19:15];
        rs2_o         = '0;   // only r-type, store and branch read rs2
        rd_o          = '0;
        imm_o         = '0;
        alu_op_o      = ADD;
        alu_src_imm_o = 1'b0;
        reg_we_o      = 1'b0;
        mem_re_o      = 1'b0;
        mem_we_o      = 1'b0;
        branch_o      = 1'b0;
        illegal       = 1'b0;
        case (opcode)
            OPC_RTYPE:
            begin
                rs2_o    = instr_i[24:20];
                rd_o     = instr_i[11:7];
                reg_we_o = 1'b1;
                if (funct7 == F7_ALT && funct3 == F3_ADD)
                    alu_op_o = SUB;
                else if (funct7 != F7_BASE)
                    illegal = 1'b1;
                else if (funct3 == F3_ADD)
                    alu_op_o = ADD;
                else if (funct3 == F3_SLT)
                    alu_op_o = SLT;
                else if (funct3 == F3_OR)
                    alu_op_o = OR;
                else if (funct3 == F3_AND)
                    alu_op_o = AND;
                else
                    illegal = 1'b1;
            end
            OPC_ITYPE, OPC_LOAD:
            begin
                rd_o          = instr_i[11:7];
                imm_o         = {{20{instr_i[31]}}, instr_i[31:20]};   // i-format
                alu_src_imm_o = 1'b1;
                reg_we_o      = 1'b1;
                mem_re_o      = (opcode == OPC_LOAD);
                // addi is the only i-type op, lw the only load width
                illegal = (opcode == OPC_LOAD) ? (funct3 != F3_WORD) : (funct3 != F3_ADD);
            end
            OPC_STORE:
            begin
                rs2_o         = instr_i[24:20];
                imm_o         = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};   // s-format
                alu_src_imm_o = 1'b1;
                mem_we_o      = 1'b1;
                illegal       = (funct3 != F3_WORD);
            end
            OPC_BRANCH:
            begin
                rs2_o    = instr_i[24:20];
                imm_o    = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};   // b-format, even offsets
                alu_op_o = SUB;   // beq taken when a - b is zero
                branch_o = 1'b1;
                illegal  = (funct3 != F3_BEQ);
            end
            default: illegal = 1'b1;
        endcase

        if (illegal)
        begin
            // bubble, nothing reads or writes
            rs1_o    = '0;
            rs2_o    = '0;
            rd_o     = '0;
            reg_we_o = 1'b0;
            mem_re_o = 1'b0;
            mem_we_o = 1'b0;
            branch_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  ra1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  ra2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  wa_i,
    input  logic                           we_i,
    input  logic [rv_pkg::XLEN-1:0]        wd_i,
    output logic [rv_pkg::XLEN-1:0]        rd1_o,
    output logic [rv_pkg::XLEN-1:0]        rd2_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs_q [1:31];   // x0 has no storage

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end
        else if (we_i && wa_i != '0)   // writes to x0 dropped
            regs_q[wa_i] <= wd_i;
    end

    // port 1, bypass so writeback and decode meet in one cycle
    always_comb
    begin
        if (ra1_i == '0)
            rd1_o = '0;
        else if (we_i && ra1_i == wa_i)
            rd1_o = wd_i;
        else
            rd1_o = regs_q[ra1_i];
    end

    always_comb
    begin
        if (ra2_i == '0)
            rd2_o = '0;
        else if (we_i && ra2_i == wa_i)   // same bypass on port 2
            rd2_o = wd_i;
        else
            rd2_o = regs_q[ra2_i];
    end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [rv_pkg::XLEN-1:0]  a_i,
    input  logic [rv_pkg::XLEN-1:0]  b_i,
    input  rv_pkg::alu_op_e          op_i,
    output logic [rv_pkg::XLEN-1:0]  y_o,
    output logic                     zero_o   // beq decision
);
    import rv_pkg::*;

    logic lt;   // signed compare for slt

    assign lt = $signed(a_i) < $signed(b_i);

    always_comb
    begin
        case (op_i)
            ADD:     y_o = a_i + b_i;
            SUB:     y_o = a_i - b_i;
            AND:     y_o = a_i & b_i;
            OR:      y_o = a_i | b_i;
            SLT:     y_o = {{(XLEN-1){1'b0}}, lt};
            default: y_o = '0;
        endcase
    end

    assign zero_o = (y_o == '0);

endmodule

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rs1_d_i,   // sources in decode
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rs2_d_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rs1_e_i,   // sources in execute
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rs2_e_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rd_e_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rd_m_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  rd_w_i,
    input  logic                           reg_we_m_i,
    input  logic                           reg_we_w_i,
    input  logic                           load_e_i,           // lw sitting in execute
    input  logic                           branch_taken_e_i,
    output rv_pkg::fwd_sel_e               fwd_a_e_o,
    output rv_pkg::fwd_sel_e               fwd_b_e_o,
    output logic                           stall_pc_o,
    output logic                           stall_fd_o,
    output logic                           flush_fd_o,
    output logic                           flush_de_o
);
    import rv_pkg::*;

    logic load_use;   // decode needs a value still in data memory

    // memory stage is younger so it is checked first
    function automatic fwd_sel_e fwd_pick(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [REG_ADDR_W-1:0] rd_m,
        input logic                  we_m,
        input logic [REG_ADDR_W-1:0] rd_w,
        input logic                  we_w
    );
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (rs == '0)
            sel = FWD_NONE;   // x0 is always zero, never forwarded
        else if (we_m && rs == rd_m)
            sel = FWD_MEM;
        else if (we_w && rs == rd_w)
            sel = FWD_WB;
        return sel;
    endfunction

    assign fwd_a_e_o = fwd_pick(rs1_e_i, rd_m_i, reg_we_m_i, rd_w_i, reg_we_w_i);
    assign fwd_b_e_o = fwd_pick(rs2_e_i, rd_m_i, reg_we_m_i, rd_w_i, reg_we_w_i);

    assign load_use = load_e_i && (rd_e_i != '0) &&
                      ((rs1_d_i == rd_e_i) || (rs2_d_i == rd_e_i));

    // a taken branch kills the stalled pair anyway, so it overrides
    assign stall_pc_o = load_use && !branch_taken_e_i;
    assign stall_fd_o = load_use && !branch_taken_e_i;   // hold, do not flush
    assign flush_fd_o = branch_taken_e_i;
    assign flush_de_o = branch_taken_e_i || load_use;     // bubble into execute

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic                     clk_i,
    input  logic                     rst_i,
    output logic [rv_pkg::XLEN-1:0]  imem_addr_o,    // fetch pc
    input  logic [31:0]              imem_data_i,    // same-cycle read
    output logic [rv_pkg::XLEN-1:0]  dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0]  dmem_wdata_o,
    output logic                     dmem_we_o,      // one-cycle write strobe
    output logic                     dmem_re_o,
    input  logic [rv_pkg::XLEN-1:0]  dmem_rdata_i    // same-cycle read
);
    import rv_pkg::*;

    // fetch
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    // decode
    logic [31:0]           instr_d;
    logic [XLEN-1:0]       pc_d;
    logic [REG_ADDR_W-1:0] rs1_d, rs2_d, rd_d;
    logic [XLEN-1:0]       imm_d, rd1_d, rd2_d;
    alu_op_e               alu_ctl_d;
    logic                  alu_src_imm_d, reg_we_d, mem_re_d, mem_we_d, branch_d;

    // execute
    logic [REG_ADDR_W-1:0] rs1_e, rs2_e, rd_e;
    logic [XLEN-1:0]       rd1_e, rd2_e, imm_e, pc_e;
    alu_op_e               alu_ctl_e;
    logic                  alu_src_imm_e, reg_we_e, mem_re_e, mem_we_e, branch_e;
    fwd_sel_e              fwd_a_e, fwd_b_e;
    logic [XLEN-1:0]       src_a_e, src_b_e, alu_b_e, alu_y_e;
    logic                  alu_zero_e;
    logic                  branch_taken_e;
    logic [XLEN-1:0]       branch_target_e;

    // memory and writeback
    logic [REG_ADDR_W-1:0] rd_m, rd_w;
    logic                  reg_we_m, mem_re_m, mem_we_m;
    logic [XLEN-1:0]       alu_y_m, wdata_m;
    logic                  reg_we_w, mem_re_w;
    logic [XLEN-1:0]       alu_y_w, load_w, result_w;

    // hazard control
    logic stall_pc, stall_fd, flush_fd, flush_de;

    assign imem_addr_o = pc_q;
    assign pc_next     = branch_taken_e ? branch_target_e : pc_q + XLEN'(4);

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            pc_q <= '0;
        else if (!stall_pc)
            pc_q <= pc_next;
    end

    // fetch/decode register, a nop acts as the bubble
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_fd)
            instr_d <= NOP_INSTR;
        else if (!stall_fd)
            instr_d <= imem_data_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_fd)
            pc_d <= pc_q;
    end

    decoder u_decoder (
        .instr_i       (instr_d),
        .rs1_o         (rs1_d),
        .rs2_o         (rs2_d),
        .rd_o          (rd_d),
        .imm_o         (imm_d),
        .alu_op_o      (alu_ctl_d),
        .alu_src_imm_o (alu_src_imm_d),
        .reg_we_o      (reg_we_d),
        .mem_re_o      (mem_re_d),
        .mem_we_o      (mem_we_d),
        .branch_o      (branch_d)
    );

    reg_file u_reg_file (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ra1_i (rs1_d),
        .ra2_i (rs2_d),
        .wa_i  (rd_w),       // written from writeback
        .we_i  (reg_we_w),
        .wd_i  (result_w),
        .rd1_o (rd1_d),
        .rd2_o (rd2_d)
    );

    // decode/execute register, control half
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_de)
        begin
            rs1_e         <= '0;
            rs2_e         <= '0;
            rd_e          <= '0;
            alu_ctl_e     <= ADD;
            alu_src_imm_e <= 1'b0;
            reg_we_e      <= 1'b0;
            mem_re_e      <= 1'b0;
            mem_we_e      <= 1'b0;
            branch_e      <= 1'b0;
        end
        else
        begin
            rs1_e         <= rs1_d;
            rs2_e         <= rs2_d;
            rd_e          <= rd_d;
            alu_ctl_e     <= alu_ctl_d;
            alu_src_imm_e <= alu_src_imm_d;
            reg_we_e      <= reg_we_d;
            mem_re_e      <= mem_re_d;
            mem_we_e      <= mem_we_d;
            branch_e      <= branch_d;
        end
    end

    always_ff @(posedge clk_i)
    begin
        rd1_e <= rd1_d;   // payload, meaningless once a bubble goes in
        rd2_e <= rd2_d;
        imm_e <= imm_d;
        pc_e  <= pc_d;
    end

    // operand select by fwd_sel_e
    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        logic [XLEN-1:0] v;
        case (sel)
            FWD_MEM: v = mem_val;
            FWD_WB:  v = wb_val;
            default: v = reg_val;
        endcase
        return v;
    endfunction

    assign src_a_e = fwd_mux(fwd_a_e, rd1_e, alu_y_m, result_w);
    assign src_b_e = fwd_mux(fwd_b_e, rd2_e, alu_y_m, result_w);   // also the store data
    assign alu_b_e = alu_src_imm_e ? imm_e : src_b_e;

    alu u_alu (
        .a_i    (src_a_e),
        .b_i    (alu_b_e),
        .op_i   (alu_ctl_e),
        .y_o    (alu_y_e),
        .zero_o (alu_zero_e)
    );

    assign branch_taken_e  = branch_e && alu_zero_e;
    assign branch_target_e = pc_e + imm_e;   // pc relative to the beq itself

    hazard_unit u_hazard_unit (
        .rs1_d_i          (rs1_d),
        .rs2_d_i          (rs2_d),
        .rs1_e_i          (rs1_e),
        .rs2_e_i          (rs2_e),
        .rd_e_i           (rd_e),
        .rd_m_i           (rd_m),
        .rd_w_i           (rd_w),
        .reg_we_m_i       (reg_we_m),
        .reg_we_w_i       (reg_we_w),
        .load_e_i         (mem_re_e),
        .branch_taken_e_i (branch_taken_e),
        .fwd_a_e_o        (fwd_a_e),
        .fwd_b_e_o        (fwd_b_e),
        .stall_pc_o       (stall_pc),
        .stall_fd_o       (stall_fd),
        .flush_fd_o       (flush_fd),
        .flush_de_o       (flush_de)
    );

    // execute/memory and memory/writeback registers
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            reg_we_m <= 1'b0;
            mem_re_m <= 1'b0;
            mem_we_m <= 1'b0;
            rd_m     <= '0;
            reg_we_w <= 1'b0;
            mem_re_w <= 1'b0;
            rd_w     <= '0;
        end
        else
        begin
            reg_we_m <= reg_we_e;
            mem_re_m <= mem_re_e;
            mem_we_m <= mem_we_e;
            rd_m     <= rd_e;
            reg_we_w <= reg_we_m;
            mem_re_w <= mem_re_m;   // selects load data in writeback
            rd_w     <= rd_m;
        end
    end

    always_ff @(posedge clk_i)
    begin
        alu_y_m <= alu_y_e;
        wdata_m <= src_b_e;
        alu_y_w <= alu_y_m;
        load_w  <= dmem_rdata_i;
    end

    assign dmem_addr_o  = alu_y_m;
    assign dmem_wdata_o = wdata_m;
    assign dmem_we_o    = mem_we_m;
    assign dmem_re_o    = mem_re_m;

    assign result_w = mem_re_w ? load_w : alu_y_w;

endmodule

`default_nettype wire

// File: rv_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_checker (
    input logic                           clk_i,
    input logic                           rst_i,
    input logic [rv_pkg::XLEN-1:0]        imem_addr_i,
    input logic                           dmem_we_i,
    input logic                           dmem_re_i,
    input logic [rv_pkg::REG_ADDR_W-1:0]  rs1_e_i,    // execute sources
    input logic [rv_pkg::REG_ADDR_W-1:0]  rs2_e_i,
    input rv_pkg::fwd_sel_e               fwd_a_e_i,
    input rv_pkg::fwd_sel_e               fwd_b_e_i
);
    import rv_pkg::*;

    int unsigned fail_cnt = 0;   // assertion failures, summed into the closing count
    logic        rst_q;          // reset was also high at the previous edge

    always_ff @(posedge clk_i)
    begin
        rst_q <= rst_i;
    end

    // a data access is either a read or a write
    strobe_excl_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !(dmem_we_i && dmem_re_i))
    else
    begin
        $error("data port write and read strobes are high together");
        fail_cnt++;
    end

    // pipeline registers are cleared from the second reset edge on
    reset_quiet_a: assert property (@(posedge clk_i)
        (rst_i && rst_q) |-> (!dmem_we_i && !dmem_re_i))
    else
    begin
        $error("data port strobe active while reset is held");
        fail_cnt++;
    end

    pc_aligned_a: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_addr_i[1:0] == 2'b00)
    else
    begin
        $error("fetch address is not word aligned");
        fail_cnt++;
    end

    // x0 reads as zero, so no stage may feed it
    x0_fwd_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (rs1_e_i == '0) |-> (fwd_a_e_i == FWD_NONE))
    else
    begin
        $error("operand a of x0 taken from a forwarding path");
        fail_cnt++;
    end

    x0_fwd_b: assert property (@(posedge clk_i) disable iff (rst_i)
        (rs2_e_i == '0) |-> (fwd_b_e_i == FWD_NONE))
    else
    begin
        $error("operand b of x0 taken from a forwarding path");
        fail_cnt++;
    end

endmodule

bind rv_core rv_core_checker u_rv_core_checker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .imem_addr_i (imem_addr_o),
    .dmem_we_i   (dmem_we_o),
    .dmem_re_i   (dmem_re_o),
    .rs1_e_i     (rs1_e),
    .rs2_e_i     (rs2_e),
    .fwd_a_e_i   (fwd_a_e),
    .fwd_b_e_i   (fwd_b_e)
);

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 5;   // 10 ns clock

    initial
    begin
        clk_o = 1'b0;
        forever
            #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [31:0] LCG_SEED       = 32'h16b70087;
    localparam int          TIMEOUT_MARGIN = 100;
    localparam int          IMEM_DEPTH     = 64;    // words
    localparam int          DMEM_DEPTH     = 256;   // words
    localparam int          TEST_DEPTH     = 256;   // words of the test file
    localparam int          IMEM_AW        = $clog2(IMEM_DEPTH);
    localparam int          DMEM_AW        = $clog2(DMEM_DEPTH);
    localparam int          RESET_CYCLES   = 16;
    localparam int          DRAIN_CYCLES   = 16;    // watch window for stray stores
    localparam int          DRIVE_DELAY    = 1;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] imem_addr;
    logic [31:0]     imem_data;
    logic [XLEN-1:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic            dmem_we, dmem_re;

    logic [31:0]     imem [0:IMEM_DEPTH-1];
    logic [XLEN-1:0] dmem [0:DMEM_DEPTH-1];
    logic [31:0]     test_words [0:TEST_DEPTH-1];   // counts, program, store pairs
    logic [31:0]     num_instr, num_stores;
    logic [XLEN-1:0] exp_addr, exp_data;

    int stores_seen  = 0;
    int cycle_cnt    = 0;
    int cycle_limit  = 0;
    int mismatch_cnt = 0;
    int extra_cnt    = 0;
    int missing_cnt  = 0;
    int timeout_cnt  = 0;
    int load_err_cnt = 0;
    int error_cnt    = 0;

    tb_clk_gen u_clk_gen (.clk_o(clk));

    rv_core dut_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_re_o    (dmem_re),
        .dmem_rdata_i (dmem_rdata)
    );

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[IMEM_AW+1:2]];
    // data only while the read level is up, unknown otherwise
    assign dmem_rdata = (dmem_re === 1'b1) ? dmem[dmem_addr[DMEM_AW+1:2]] : 'x;

    always @(posedge clk)
    begin
        if (dmem_we === 1'b1)
            dmem[dmem_addr[DMEM_AW+1:2]] <= dmem_wdata;
    end

    always @(posedge clk)
    begin
        if (!rst)
            cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_tests();
        for (int i = 0; i < TEST_DEPTH; i++)
            test_words[i] = 'x;
        $readmemh("rv_core_tests.txt", test_words);
        num_instr  = test_words[0];
        num_stores = test_words[1];
        assert (num_instr > 0 && num_instr <= IMEM_DEPTH &&
                2 + num_instr + 2 * num_stores <= TEST_DEPTH)
        else
        begin
            $display("test file rv_core_tests.txt is missing or its counts are out of range");
            load_err_cnt++;
            num_instr  = 0;
            num_stores = 0;
        end
    endtask

    task automatic fill_imem();
        for (int i = 0; i < IMEM_DEPTH; i++)
            imem[i] = (i < num_instr) ? test_words[2 + i] : NOP_INSTR;   // nop padding
    endtask

    task automatic preset_dmem();
        logic [31:0] state;
        state = LCG_SEED;
        for (int i = 0; i < DMEM_DEPTH; i++)
        begin
            state   = lcg_next(state);   // word i holds the (i+1)-th value
            dmem[i] = state;
        end
    endtask

    // strobe outputs come from flops, stable by mid cycle
    always @(negedge clk)
    begin
        if (!rst && dmem_we === 1'b1)
        begin
            assert (stores_seen < num_stores)
            else
            begin
                $display("store to address %h after the last expected store", dmem_addr);
                extra_cnt++;
            end
            if (stores_seen < num_stores)
            begin
                exp_addr = test_words[2 + num_instr + 2 * stores_seen];
                exp_data = test_words[3 + num_instr + 2 * stores_seen];
                assert (dmem_addr === exp_addr)
                else
                begin
                    $display("[ERROR] %0t dmem_addr_o expected %h got %h",
                             $time, exp_addr, dmem_addr);
                    mismatch_cnt++;
                end
                assert (dmem_wdata === exp_data)
                else
                begin
                    $display("[ERROR] %0t dmem_wdata_o expected %h got %h",
                             $time, exp_data, dmem_wdata);
                    mismatch_cnt++;
                end
                stores_seen++;
            end
        end
    end

    initial
    begin
        rst = 1'b1;
        load_tests();
        fill_imem();
        preset_dmem();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        cycle_limit = 8 * num_instr + TIMEOUT_MARGIN;
        while (stores_seen < num_stores && cycle_cnt < cycle_limit)
            @(posedge clk);
        if (stores_seen < num_stores)
        begin
            $display("timeout after %0d cycles with %0d of %0d expected stores seen",
                     cycle_cnt, stores_seen, num_stores);
            timeout_cnt = 1;
            missing_cnt = num_stores - stores_seen;
        end
        else
            repeat (DRAIN_CYCLES) @(posedge clk);   // self-loop must stay silent
        error_cnt = mismatch_cnt + extra_cnt + missing_cnt + timeout_cnt + load_err_cnt
                    + dut_i.u_rv_core_checker.fail_cnt;
        $display("errors %0d: mismatch %0d extra %0d missing %0d timeout %0d file %0d sva %0d",
                 error_cnt, mismatch_cnt, extra_cnt, missing_cnt, timeout_cnt,
                 load_err_cnt, dut_i.u_rv_core_checker.fail_cnt);
        if (error_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rv_pkg.sv
decoder.sv
reg_file.sv
alu.sv
hazard_unit.sv
rv_core.sv
rv_core_checker.sv
tb_clk_gen.sv
tb_rv_core.sv

// File: rv_core_tests.txt
// word 0 program length, word 1 number of expected stores
// then one instruction word per line, then store records: address data
0000001C
0000000A
00500093 // 00 addi x1,x0,5
00700113 // 04 addi x2,x0,7
002081B3 // 08 add  x3,x1,x2     x2 from memory stage
40118233 // 0c sub  x4,x3,x1     x3 from memory stage
10302023 // 10 sw   x3,0x100(x0)
10402223 // 14 sw   x4,0x104(x0)
00100293 // 18 addi x5,x0,1
00200293 // 1c addi x5,x0,2
10502423 // 20 sw   x5,0x108(x0) newer x5 must win
00002303 // 24 lw   x6,0(x0)     first lcg word
001303B3 // 28 add  x7,x6,x1     load-use stall
10702623 // 2c sw   x7,0x10c(x0)
00108663 // 30 beq  x1,x1,+12    taken
10102823 // 34 sw   x1,0x110(x0) discarded
10202A23 // 38 sw   x2,0x114(x0) discarded
10202C23 // 3c sw   x2,0x118(x0)
00208463 // 40 beq  x1,x2,+8     not taken
10302E23 // 44 sw   x3,0x11c(x0)
00900013 // 48 addi x0,x0,9
12002023 // 4c sw   x0,0x120(x0)
FFD00493 // 50 addi x9,x0,-3
0014A433 // 54 slt  x8,x9,x1
0024F533 // 58 and  x10,x9,x2
0024E5B3 // 5c or   x11,x9,x2
12802223 // 60 sw   x8,0x124(x0)
12A02423 // 64 sw   x10,0x128(x0)
12B02623 // 68 sw   x11,0x12c(x0)
00000063 // 6c beq  x0,x0,0      self-loop
00000100 0000000C // 5 + 7
00000104 00000007 // 12 - 5
00000108 00000002
0000010C 5B1EC43F // lcg word 0 + 5
00000118 00000007
0000011C 0000000C
00000120 00000000 // x0 stays zero
00000124 00000001 // -3 < 5 signed
00000128 00000005
0000012C FFFFFFFF
